// File: rvPipelineTop.f
src/rvIsaPkg.sv
src/rvCorePkg.sv
src/regPortIf.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/registerFile.sv
src/rvPipelineTop.sv
sim/rvPipelineTop_assertions.sv
sim/rvPipelineTop_tb.sv

// File: sim/rvPipelineTop_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rvPipelineTop_assertions (
    input wire logic                        clk_i,
    input wire logic                        reset_i,
    input wire logic                        trigger_i,
    input wire logic [rvCorePkg::XLEN-1:0]  a0_i
);

    int   failCount = 0;
    logic idle;

    // Idle from reset until the start pulse
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            idle <= 1'b1;
        end else if (trigger_i) begin
            idle <= 1'b0;
        end
    end

    // Reset clears the register file including a0
    assert property (@(posedge clk_i) reset_i |=> a0_i == '0)
        else begin
            failCount++;
            $error("a0_o not zero in the cycle after reset");
        end

    // Nothing retires before the start pulse
    assert property (@(posedge clk_i) (idle && !reset_i) |=> $stable(a0_i))
        else begin
            failCount++;
            $error("a0_o changed while the core was idle");
        end

endmodule

bind rvPipelineTop rvPipelineTop_assertions rvPipelineTop_assertions_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .trigger_i (trigger_i),
    .a0_i      (a0_o)
);

`default_nettype wire

// File: sim/rvPipelineTop_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rvPipelineTop_tb;

    localparam int          CLK_HALF     = 4;
    localparam int          DRIVE_DELAY  = 1;
    localparam int          RESET_CYCLES = 3;
    localparam int          STIM_WORDS   = 1024;
    localparam int          MARGIN       = 100;
    localparam logic [31:0] END_MARK     = 32'hFFFF_FFFF;
    localparam string       STIM_FILE    = "sim/rvPipeline_stimulus.txt";

    logic                           clk_i = 1'b0;
    logic                           reset_i;
    logic                           trigger_i;
    logic                           imemWe_i;
    logic [rvCorePkg::IMEM_AW-1:0]  imemAddr_i;
    logic [rvCorePkg::XLEN-1:0]     imemData_i;
    logic [rvCorePkg::XLEN-1:0]     a0_o;

    // Raw stimulus words and the parsed test table
    logic [31:0] stimMem [STIM_WORDS];
    logic [31:0] testNames [$];
    logic [31:0] expects [$];
    int          budgets [$];
    int          progStarts [$];
    int          progLens [$];

    int passCount;
    int failCount;

    always #CLK_HALF clk_i = ~clk_i;

    rvPipelineTop rvPipelineTop_inst (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .trigger_i  (trigger_i),
        .imemWe_i   (imemWe_i),
        .imemAddr_i (imemAddr_i),
        .imemData_i (imemData_i),
        .a0_o       (a0_o)
    );

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    task automatic stepCycle();
        @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    task automatic finishRun(input bit failed);
        if (failed) begin
            $display("Simulation finished: FAIL");
        end else begin
            $display("Simulation finished: PASS");
        end
        $finish;
    endtask

    // Three header words and the program words up to the end marker
    task automatic parseStimulus(output bit ok);
        int ptr;
        int start;
        ok = 1'b1;
        $readmemh(STIM_FILE, stimMem);
        ptr = 0;
        while (ptr + 3 <= STIM_WORDS && !$isunknown(stimMem[ptr]) && stimMem[ptr] != '0) begin
            testNames.push_back(stimMem[ptr]);
            budgets.push_back(int'(stimMem[ptr + 1]));
            expects.push_back(stimMem[ptr + 2]);
            ptr = ptr + 3;
            start = ptr;
            while (ptr < STIM_WORDS && stimMem[ptr] !== END_MARK) begin
                ptr++;
            end
            if (ptr >= STIM_WORDS || ptr - start > rvCorePkg::IMEM_WORDS) begin
                ok = 1'b0;
            end
            progStarts.push_back(start);
            progLens.push_back(ptr - start);
            ptr++;
        end
        if (testNames.size() == 0) begin
            ok = 1'b0;
        end
    endtask

    task automatic watchdog();
        int limit;
        limit = MARGIN;
        foreach (budgets[t]) begin
            limit += budgets[t] + RESET_CYCLES + rvCorePkg::IMEM_WORDS + 2;
        end
        repeat (limit) @(posedge clk_i);
        $display("timeout: the tests did not finish within %0d cycles", limit);
        finishRun(1'b1);
    endtask

    task automatic resetCore();
        reset_i = 1'b1;
        repeat (RESET_CYCLES) stepCycle();
        reset_i = 1'b0;
    endtask

    // Program from word 0 with NOPs after it
    task automatic loadProgram(input int start, input int len);
        imemWe_i = 1'b1;
        for (int a = 0; a < rvCorePkg::IMEM_WORDS; a++) begin
            imemAddr_i = a[rvCorePkg::IMEM_AW-1:0];
            imemData_i = (a < len) ? stimMem[start + a] : rvIsaPkg::NOP_WORD;
            stepCycle();
        end
        imemWe_i = 1'b0;
    endtask

    task automatic checkA0(input logic [rvCorePkg::XLEN-1:0] actual,
                           input logic [rvCorePkg::XLEN-1:0] expected,
                           input logic [31:0]                name);
        if (actual !== expected) begin
            $display("error a0_o test %s expected %h actual %h", name, expected, actual);
            failCount++;
        end else begin
            $display("test %s passed, a0_o %h", name, actual);
            passCount++;
        end
    endtask

    task automatic runTest(input int t);
        resetCore();
        loadProgram(progStarts[t], progLens[t]);
        trigger_i = 1'b1;
        stepCycle();
        trigger_i = 1'b0;
        repeat (budgets[t]) stepCycle();
        checkA0(a0_o, expects[t], testNames[t]);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        bit stimOk;
        int assertFails;
        reset_i    = 1'b1;
        trigger_i  = 1'b0;
        imemWe_i   = 1'b0;
        imemAddr_i = '0;
        imemData_i = '0;
        passCount  = 0;
        failCount  = 0;
        parseStimulus(stimOk);
        if (!stimOk) begin
            $display("stimulus file %s is missing or malformed", STIM_FILE);
            finishRun(1'b1);
        end else begin
            fork
                watchdog();
            join_none
            foreach (budgets[t]) begin
                runTest(t);
            end
            assertFails = rvPipelineTop_inst.rvPipelineTop_assertions_inst.failCount;
            $display("tests passed %0d, failed %0d, assertion failures %0d",
                     passCount, failCount, assertFails);
            finishRun(failCount != 0 || assertFails != 0);
        end
    end

endmodule

`default_nettype wire

// File: sim/rvPipeline_stimulus.txt
// Header per test: name as four ASCII bytes, cycle budget, expected a0
// Program words follow, closed by the end marker ffffffff
// arit: OP and OP_IMM arithmetic, logic, compares and shifts
61726974 00000040 000001b6
00700093 ffd00113 00000013 00000013 00000013 402081b3 00112233 00409293
01c15313 00000013 00000013 00000013 004183b3 0062c433 00000013 00000013
00000013 0083f4b3 03c47593 1003e613 ffe12693 00000013 00000013 00000013
00d64733 00b4e7b3 00000013 00000013 00000013 00f70533 00000013 00000013
00000013 0ff54513 0000006f 00000013 00000013
ffffffff
// auip: LUI plus AUIPC at pc 4
61756970 00000020 12346004
123450b7 00001517 00000013 00000013 00000013 00150533 0000006f 00000013
00000013
ffffffff
// ldst: two stores then a load of the first word
6c647374 00000020 abcde123
04000093 abcde137 00000013 00000013 00000013 12310113 00000013 00000013
00000013 0020a423 0010a623 0080a503 0000006f 00000013 00000013
ffffffff
// brch: each branch taken and not taken, skipped slots poison x5
62726368 00000050 0000003f
00500093 fff00113 00000013 00000013 00000013 00108863 00100193 00200213
7ff00293 00109863 00000013 00000013 00400313 00114863 00800393 00000013
7ff00293 00115863 00000013 00000013 01000413 0020d863 00000013 00000013
7ff00293 0020c863 00000013 00000013 02000493 00000013 00000013 00000013
00418533 007305b3 00940633 00000013 00000013 00000013 00b50533 00560633
00000013 00000013 00000013 00c50533 0000006f 00000013 00000013
ffffffff
// jump: JAL and JALR return addresses summed
6a756d70 00000020 00000038
03000093 00000013 00000013 00000013 010002ef 00000013 00000013 7ff00313
00408567 00000013 00000013 7ff00313 7ff00313 006285b3 00000013 00000013
00000013 00b50533 0000006f 00000013 00000013
ffffffff
// zero: x0 writes dropped, x5 and x10 cleared by reset
7a65726f 00000020 0000005a
05500013 fffff037 00000013 00000013 00000013 005005b3 00050633 00000013
00000013 00000013 00c58533 00000013 00000013 00000013 05a50513 0000006f
00000013 00000013
ffffffff

// File: src/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  wire logic                        clk_i,
    input  wire logic                        reset_i,
    input  wire logic [rvCorePkg::XLEN-1:0]  instr_i,
    input  wire logic [rvCorePkg::XLEN-1:0]  pc_i,
    input  wire logic [rvCorePkg::XLEN-1:0]  pcPlus4_i,
    regPortIf.consumer                       regs,
    output rvCorePkg::decExT                 decEx_o
);

    rvIsaPkg::opcodeE            opcode;
    rvIsaPkg::immFmtE            immFmt;
    rvCorePkg::decExT            decNext;
    logic                        bIsImm;
    logic [rvCorePkg::XLEN-1:0]  imm;

    // funct3 to ALU operation for OP and OP_IMM
    function automatic rvIsaPkg::aluOpE aluFromFunct3(input logic [2:0] f3,
                                                      input logic subBit);
        case (f3)
            3'b000:  return subBit ? rvIsaPkg::SUB : rvIsaPkg::ADD;
            3'b001:  return rvIsaPkg::SLL;
            3'b010:  return rvIsaPkg::SLT;
            3'b100:  return rvIsaPkg::XOR;
            3'b101:  return rvIsaPkg::SRL;
            3'b110:  return rvIsaPkg::OR;
            3'b111:  return rvIsaPkg::AND;
            default: return rvIsaPkg::ADD;
        endcase
    endfunction

    assign opcode       = rvIsaPkg::opcodeE'(instr_i[6:0]);
    assign regs.rs1Addr = instr_i[19:15];
    assign regs.rs2Addr = instr_i[24:20];

    ////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        decNext = '0;
        immFmt  = rvIsaPkg::I;
        bIsImm  = 1'b1;
        case (opcode)
            rvIsaPkg::OP: begin
                decNext.aluOp    = aluFromFunct3(instr_i[14:12], instr_i[30]);
                decNext.regWrite = 1'b1;
                bIsImm           = 1'b0;
            end
            rvIsaPkg::OP_IMM: begin
                decNext.aluOp    = aluFromFunct3(instr_i[14:12], 1'b0);
                decNext.regWrite = 1'b1;
            end
            rvIsaPkg::LUI: begin
                decNext.aluOp    = rvIsaPkg::PASS_B;
                decNext.regWrite = 1'b1;
                immFmt           = rvIsaPkg::U;
            end
            rvIsaPkg::AUIPC: begin
                decNext.aIsPc    = 1'b1;
                decNext.regWrite = 1'b1;
                immFmt           = rvIsaPkg::U;
            end
            rvIsaPkg::LOAD: begin
                decNext.memToReg = 1'b1;
                decNext.regWrite = 1'b1;
            end
            rvIsaPkg::STORE: begin
                decNext.memWrite = 1'b1;
                immFmt           = rvIsaPkg::S;
            end
            rvIsaPkg::BRANCH: begin
                decNext.isBranch = 1'b1;
                immFmt           = rvIsaPkg::B;
            end
            rvIsaPkg::JAL: begin
                decNext.isJump   = 1'b1;
                decNext.regWrite = 1'b1;
                immFmt           = rvIsaPkg::J;
            end
            rvIsaPkg::JALR: begin
                decNext.isJump   = 1'b1;
                decNext.isJalr   = 1'b1;
                decNext.regWrite = 1'b1;
            end
            // Unknown opcodes stay a bubble
            default: ;
        endcase

        decNext.funct3  = instr_i[14:12];
        decNext.rd      = instr_i[11:7];
        decNext.pc      = pc_i;
        decNext.pcPlus4 = pcPlus4_i;
        decNext.rs1Val  = regs.rs1Data;
        decNext.rs2Val  = regs.rs2Data;
        decNext.imm     = imm;
        decNext.opB     = bIsImm ? imm : regs.rs2Data;
    end

    // Sign-extended immediate
    always_comb begin
        case (immFmt)
            rvIsaPkg::S: imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            rvIsaPkg::B: imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                                instr_i[30:25], instr_i[11:8], 1'b0};
            rvIsaPkg::U: imm = {instr_i[31:12], 12'b0};
            rvIsaPkg::J: imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                                instr_i[20], instr_i[30:21], 1'b0};
            default:     imm = {{20{instr_i[31]}}, instr_i[31:20]};
        endcase
    end

    // Decode/execute register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            decEx_o <= '0;
        end else begin
            decEx_o <= decNext;
        end
    end

endmodule

`default_nettype wire

// File: src/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire logic                        clk_i,
    input  wire logic                        reset_i,
    input  wire rvCorePkg::decExT            decEx_i,
    output logic                             redirect_o,
    output logic [rvCorePkg::XLEN-1:0]       redirectPc_o,
    output rvCorePkg::exMemT                 exMem_o
);

    logic [rvCorePkg::XLEN-1:0]  opA;
    logic [rvCorePkg::XLEN-1:0]  aluResult;
    logic                        branchCond;

    // AUIPC adds to the pc
    assign opA = decEx_i.aIsPc ? decEx_i.pc : decEx_i.rs1Val;

    always_comb begin
        case (decEx_i.aluOp)
            rvIsaPkg::SUB:    aluResult = opA - decEx_i.opB;
            rvIsaPkg::AND:    aluResult = opA & decEx_i.opB;
            rvIsaPkg::OR:     aluResult = opA | decEx_i.opB;
            rvIsaPkg::XOR:    aluResult = opA ^ decEx_i.opB;
            rvIsaPkg::SLT:    aluResult = {31'b0, $signed(opA) < $signed(decEx_i.opB)};
            rvIsaPkg::SLL:    aluResult = opA << decEx_i.opB[4:0];
            rvIsaPkg::SRL:    aluResult = opA >> decEx_i.opB[4:0];
            rvIsaPkg::PASS_B: aluResult = decEx_i.opB;
            default:          aluResult = opA + decEx_i.opB;
        endcase
    end

    // Branch compare on the raw register values
    always_comb begin
        case (decEx_i.funct3)
            rvIsaPkg::BR_EQ: branchCond = decEx_i.rs1Val == decEx_i.rs2Val;
            rvIsaPkg::BR_NE: branchCond = decEx_i.rs1Val != decEx_i.rs2Val;
            rvIsaPkg::BR_LT: branchCond = $signed(decEx_i.rs1Val) < $signed(decEx_i.rs2Val);
            rvIsaPkg::BR_GE: branchCond = $signed(decEx_i.rs1Val) >= $signed(decEx_i.rs2Val);
            default:         branchCond = 1'b0;
        endcase
    end

    assign redirect_o   = (decEx_i.isBranch & branchCond) | decEx_i.isJump;
    assign redirectPc_o = decEx_i.isJalr ? {aluResult[rvCorePkg::XLEN-1:1], 1'b0}
                                         : decEx_i.pc + decEx_i.imm;

    // Execute/memory register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            exMem_o.memWrite <= 1'b0;
            exMem_o.regWrite <= 1'b0;
            exMem_o.memToReg <= 1'b0;
            exMem_o.isJump   <= 1'b0;
        end else begin
            exMem_o.memWrite <= decEx_i.memWrite;
            exMem_o.regWrite <= decEx_i.regWrite;
            exMem_o.memToReg <= decEx_i.memToReg;
            exMem_o.isJump   <= decEx_i.isJump;
        end
        exMem_o.aluResult <= aluResult;
        exMem_o.storeData <= decEx_i.rs2Val;
        exMem_o.pcPlus4   <= decEx_i.pcPlus4;
        exMem_o.rd        <= decEx_i.rd;
    end

endmodule

`default_nettype wire

// File: src/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
    input  wire logic                             clk_i,
    input  wire logic                             reset_i,
    input  wire logic                             trigger_i,
    input  wire logic                             imemWe_i,
    input  wire logic [rvCorePkg::IMEM_AW-1:0]    imemAddr_i,
    input  wire logic [rvCorePkg::XLEN-1:0]       imemData_i,
    input  wire logic                             redirect_i,
    input  wire logic [rvCorePkg::XLEN-1:0]       redirectPc_i,
    output logic      [rvCorePkg::XLEN-1:0]       instr_o,
    output logic      [rvCorePkg::XLEN-1:0]       pc_o,
    output logic      [rvCorePkg::XLEN-1:0]       pcPlus4_o
);

    logic                        running;
    logic [rvCorePkg::XLEN-1:0]  pc;
    logic [rvCorePkg::XLEN-1:0]  pcPlus4;
    logic [rvCorePkg::XLEN-1:0]  fetchedInstr;

    logic [rvCorePkg::XLEN-1:0]  imem [rvCorePkg::IMEM_WORDS];

    assign pcPlus4      = pc + 32'd4;
    assign fetchedInstr = imem[pc[rvCorePkg::IMEM_AW+1:2]];

    // Start flag and program counter
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            running <= 1'b0;
            pc      <= '0;
        end else begin
            if (trigger_i) begin
                running <= 1'b1;
            end
            if (running) begin
                pc <= redirect_i ? redirectPc_i : pcPlus4;
            end
        end
    end

    // Word-addressed program load port
    always_ff @(posedge clk_i) begin
        if (imemWe_i) begin
            imem[imemAddr_i] <= imemData_i;
        end
    end

    // Fetch/decode register holds bubbles until started
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            instr_o <= rvIsaPkg::NOP_WORD;
        end else begin
            instr_o <= running ? fetchedInstr : rvIsaPkg::NOP_WORD;
        end
        pc_o      <= pc;
        pcPlus4_o <= pcPlus4;
    end

endmodule

`default_nettype wire

// File: src/memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
    input  wire logic                clk_i,
    input  wire logic                reset_i,
    input  wire rvCorePkg::exMemT    exMem_i,
    regPortIf.consumer               regs
);

    rvCorePkg::memWbT            memWb;
    logic [rvCorePkg::XLEN-1:0]  loadData;

    logic [rvCorePkg::XLEN-1:0]  dmem [rvCorePkg::DMEM_WORDS];

    // Word RAM indexed by the bits above the byte offset
    assign loadData = dmem[exMem_i.aluResult[rvCorePkg::DMEM_AW+1:2]];

    always_ff @(posedge clk_i) begin
        if (exMem_i.memWrite) begin
            dmem[exMem_i.aluResult[rvCorePkg::DMEM_AW+1:2]] <= exMem_i.storeData;
        end
    end

    // Memory/writeback register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            memWb.regWrite <= 1'b0;
            memWb.memToReg <= 1'b0;
            memWb.isJump   <= 1'b0;
        end else begin
            memWb.regWrite <= exMem_i.regWrite;
            memWb.memToReg <= exMem_i.memToReg;
            memWb.isJump   <= exMem_i.isJump;
        end
        memWb.aluResult <= exMem_i.aluResult;
        memWb.loadData  <= loadData;
        memWb.pcPlus4   <= exMem_i.pcPlus4;
        memWb.rd        <= exMem_i.rd;
    end

    ////////////////////////////////////////////////////////////
    // Writeback select
    ////////////////////////////////////////////////////////////
    assign regs.writeEn   = memWb.regWrite;
    assign regs.writeAddr = memWb.rd;
    assign regs.writeData = memWb.isJump   ? memWb.pcPlus4  :
                            memWb.memToReg ? memWb.loadData : memWb.aluResult;

endmodule

`default_nettype wire

// File: src/regPortIf.sv
`timescale 1ns/1ps
`default_nettype none

interface regPortIf;

    // Read side
    logic [rvCorePkg::REG_ADDR_W-1:0] rs1Addr;
    logic [rvCorePkg::REG_ADDR_W-1:0] rs2Addr;
    logic [rvCorePkg::XLEN-1:0]       rs1Data;
    logic [rvCorePkg::XLEN-1:0]       rs2Data;

    // Write side
    logic                             writeEn;
    logic [rvCorePkg::REG_ADDR_W-1:0] writeAddr;
    logic [rvCorePkg::XLEN-1:0]       writeData;

    modport consumer (
        output rs1Addr, rs2Addr, writeEn, writeAddr, writeData,
        input  rs1Data, rs2Data
    );

    modport regs (
        input  rs1Addr, rs2Addr, writeEn, writeAddr, writeData,
        output rs1Data, rs2Data
    );

endinterface

`default_nettype wire

// File: src/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  wire logic                    clk_i,
    input  wire logic                    reset_i,
    regPortIf.regs                       regs,
    output logic [rvCorePkg::XLEN-1:0]   a0_o
);

    logic [rvCorePkg::XLEN-1:0] rf [2**rvCorePkg::REG_ADDR_W];

    // Combinational reads see the old value on a same-cycle write
    assign regs.rs1Data = rf[regs.rs1Addr];
    assign regs.rs2Data = rf[regs.rs2Addr];

    assign a0_o = rf[rvCorePkg::A0_INDEX];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 2**rvCorePkg::REG_ADDR_W; i++) begin
                rf[i] <= '0;
            end
        end else if (regs.writeEn && regs.writeAddr != '0) begin
            // x0 never written so it stays zero
            rf[regs.writeAddr] <= regs.writeData;
        end
    end

endmodule

`default_nettype wire

// File: src/rvCorePkg.sv
`default_nettype none

package rvCorePkg;

    // Datapath and memory sizes
    localparam int XLEN       = 32;
    localparam int IMEM_WORDS = 256;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);
    localparam int REG_ADDR_W = 5;
    localparam int A0_INDEX   = 10;

    // Decode to execute
    typedef struct packed {
        rvIsaPkg::aluOpE         aluOp;
        logic                    aIsPc;
        logic                    regWrite;
        logic                    memWrite;
        logic                    memToReg;
        logic                    isBranch;
        logic                    isJump;
        logic                    isJalr;
        logic [2:0]              funct3;
        logic [REG_ADDR_W-1:0]   rd;
        logic [XLEN-1:0]         pc;
        logic [XLEN-1:0]         pcPlus4;
        logic [XLEN-1:0]         rs1Val;
        logic [XLEN-1:0]         opB;
        logic [XLEN-1:0]         rs2Val;
        logic [XLEN-1:0]         imm;
    } decExT;

    // Execute to memory
    typedef struct packed {
        logic [XLEN-1:0]         aluResult;
        logic [XLEN-1:0]         storeData;
        logic                    memWrite;
        logic                    memToReg;
        logic                    regWrite;
        logic                    isJump;
        logic [XLEN-1:0]         pcPlus4;
        logic [REG_ADDR_W-1:0]   rd;
    } exMemT;

    // Memory to writeback
    typedef struct packed {
        logic [XLEN-1:0]         aluResult;
        logic [XLEN-1:0]         loadData;
        logic                    memToReg;
        logic                    regWrite;
        logic                    isJump;
        logic [XLEN-1:0]         pcPlus4;
        logic [REG_ADDR_W-1:0]   rd;
    } memWbT;

endpackage

`default_nettype wire

// File: src/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcodeE;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLT    = 4'd5,
        SLL    = 4'd6,
        SRL    = 4'd7,
        PASS_B = 4'd8
    } aluOpE;

    // Immediate layouts
    typedef enum logic [2:0] {
        I = 3'd0,
        S = 3'd1,
        B = 3'd2,
        U = 3'd3,
        J = 3'd4
    } immFmtE;

    // Branch funct3 codes
    localparam logic [2:0] BR_EQ = 3'b000;
    localparam logic [2:0] BR_NE = 3'b001;
    localparam logic [2:0] BR_LT = 3'b100;
    localparam logic [2:0] BR_GE = 3'b101;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;

endpackage

`default_nettype wire

// File: src/rvPipelineTop.sv
`timescale 1ns/1ps
`default_nettype none

module rvPipelineTop (
    input  wire logic                            clk_i,
    input  wire logic                            reset_i,
    input  wire logic                            trigger_i,
    input  wire logic                            imemWe_i,
    input  wire logic [rvCorePkg::IMEM_AW-1:0]   imemAddr_i,
    input  wire logic [rvCorePkg::XLEN-1:0]      imemData_i,
    output logic      [rvCorePkg::XLEN-1:0]      a0_o
);

    logic [rvCorePkg::XLEN-1:0]  instr;
    logic [rvCorePkg::XLEN-1:0]  pc;
    logic [rvCorePkg::XLEN-1:0]  pcPlus4;
    logic                        redirect;
    logic [rvCorePkg::XLEN-1:0]  redirectPc;
    rvCorePkg::decExT            decEx;
    rvCorePkg::exMemT            exMem;

    regPortIf regPort ();

    ////////////////////////////////////////////////////////////
    // Fetch and decode
    ////////////////////////////////////////////////////////////
    fetchStage fetchStage_inst (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .trigger_i    (trigger_i),
        .imemWe_i     (imemWe_i),
        .imemAddr_i   (imemAddr_i),
        .imemData_i   (imemData_i),
        .redirect_i   (redirect),
        .redirectPc_i (redirectPc),
        .instr_o      (instr),
        .pc_o         (pc),
        .pcPlus4_o    (pcPlus4)
    );

    decodeStage decodeStage_inst (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .instr_i   (instr),
        .pc_i      (pc),
        .pcPlus4_i (pcPlus4),
        .regs      (regPort.consumer),
        .decEx_o   (decEx)
    );

    ////////////////////////////////////////////////////////////
    // Execute, memory and writeback
    ////////////////////////////////////////////////////////////
    executeStage executeStage_inst (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .decEx_i      (decEx),
        .redirect_o   (redirect),
        .redirectPc_o (redirectPc),
        .exMem_o      (exMem)
    );

    memoryStage memoryStage_inst (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .exMem_i (exMem),
        .regs    (regPort.consumer)
    );

    registerFile registerFile_inst (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .regs    (regPort.regs),
        .a0_o    (a0_o)
    );

endmodule

`default_nettype wire
